//--- Makefile
# Verilator build and run for the NVMe host command engine

VERILATOR ?= verilator
TOP       ?= tb_nvme_host_slave
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= *** TEST PASSED ***

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv testbench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)' || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
+incdir+include
hw/nvme_host_pkg.sv
hw/nvme_host_if.sv
hw/host_axil_port.sv
hw/host_regs.sv
hw/queue_tracker.sv
hw/sq_cmd_builder.sv
hw/doorbell_writer.sv
hw/nvme_host_slave.sv
testbench/tb_clock_gen.sv
testbench/tb_nvme_host_slave.sv

//--- hw/doorbell_writer.sv
`timescale 1ns/10ps

module doorbell_writer #(
  parameter int NUM_QUEUES = 2
) (
  input  logic        axi_aclk,
  input  logic        axi_aresetn,
  doorbell_if.writer  db,
  output logic        pcie_write,
  output logic [31:0] pcie_waddr,
  output logic [31:0] pcie_wdata,
  input  logic        pcie_wdone
);

  localparam int NS = 2 * NUM_QUEUES;
  localparam int SB = $clog2(NS);

  typedef enum logic {ST_IDLE, ST_WAIT} state_e;

  state_e        state;
  logic [SB-1:0] sel;
  logic [SB-1:0] pick;

  // Lowest index wins, CQ sources sit below SQ sources
  always_comb begin
    pick = '0;
    for (int i = NS - 1; i >= 0; i--) begin
      if (db.req[i]) begin
        pick = SB'(i);
      end
    end
  end

  // Done lines up with the return to idle so the request clears in time
  always_comb begin
    db.done = '0;
    if (state == ST_WAIT && pcie_wdone) begin
      db.done[sel] = 1'b1;
    end
  end

  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      state      <= ST_IDLE;
      sel        <= '0;
      pcie_write <= 1'b0;
    end else begin
      pcie_write <= 1'b0;
      if (state == ST_IDLE && |db.req) begin
        sel        <= pick;
        pcie_write <= 1'b1;
        pcie_waddr <= db.addr[pick];
        pcie_wdata <= db.data[pick];
        state      <= ST_WAIT;
      end else if (state == ST_WAIT && pcie_wdone) begin
        state <= ST_IDLE;
      end
    end
  end

endmodule

//--- hw/host_axil_port.sv
`timescale 1ns/10ps

module host_axil_port import nvme_host_pkg::*; (
  input  logic                      axi_aclk,
  input  logic                      axi_aresetn,
  input  logic [host_addr_bits-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [31:0]               wdata,
  input  logic [3:0]                wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [host_addr_bits-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [31:0]               rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  reg_bus_if.master                 bus
);

  typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_RESP} state_e;

  state_e                    state;
  logic                      aw_got;
  logic                      w_got;
  logic [host_addr_bits-1:0] aw_addr_q;
  logic [31:0]               w_data_q;
  logic                      cyc_q;
  logic                      aw_hs;
  logic                      w_hs;
  logic                      ar_hs;
  logic                      aw_have;
  logic                      w_have;
  logic [31:0]               strb_mask;

  assign aw_hs   = awvalid & awready;
  assign w_hs    = wvalid & wready;
  assign ar_hs   = arvalid & arready;
  assign aw_have = aw_got | aw_hs;
  assign w_have  = w_got | w_hs;
  assign strb_mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};

  assign bus.cyc = cyc_q;
  assign bus.stb = cyc_q;

  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      state   <= ST_IDLE;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      cyc_q   <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw_hs) begin
            aw_got    <= 1'b1;
            aw_addr_q <= awaddr;
          end
          if (w_hs) begin
            w_got    <= 1'b1;
            w_data_q <= wdata & strb_mask;
          end
          // A read accepted alongside a write address runs first
          if (ar_hs) begin
            bus.adr <= araddr;
            bus.we  <= 1'b0;
          end else if (aw_have && w_have) begin
            bus.adr   <= aw_hs ? awaddr : aw_addr_q;
            bus.dat_w <= w_hs ? (wdata & strb_mask) : w_data_q;
            bus.we    <= 1'b1;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
          end
          if (ar_hs || (aw_have && w_have)) begin
            cyc_q   <= 1'b1;
            state   <= ST_BUS;
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
          end else begin
            awready <= !aw_have;
            wready  <= !w_have;
            arready <= !aw_have && !w_have;
          end
        end
        ST_BUS: begin
          if (bus.ack || bus.err) begin
            cyc_q <= 1'b0;
            state <= ST_RESP;
            if (bus.we) begin
              bvalid <= 1'b1;
              bresp  <= bus.err ? 2'b10 : 2'b00;
            end else begin
              rvalid <= 1'b1;
              rresp  <= bus.err ? 2'b10 : 2'b00;
              rdata  <= bus.dat_r;
            end
          end
        end
        default: begin
          if (bvalid && bready) begin
            bvalid <= 1'b0;
            state  <= ST_IDLE;
          end
          if (rvalid && rready) begin
            rvalid <= 1'b0;
            state  <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- hw/host_regs.sv
`timescale 1ns/10ps

module host_regs import nvme_host_pkg::*; #(
  parameter int NUM_QUEUES = 2,
  parameter int SQ_DEPTH   = 16
) (
  input  logic                                 axi_aclk,
  input  logic                                 axi_aresetn,
  reg_bus_if.slave                             bus,
  sq_cmd_if.source                             cmd,
  input  logic [NUM_QUEUES-1:0]                sq_full,
  input  logic [NUM_QUEUES*$clog2(SQ_DEPTH)-1:0] sq_level
);

  localparam int QB = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
  localparam int LB = $clog2(SQ_DEPTH);

  logic [31:0] control;
  logic [31:0] dptr_lo;
  logic [31:0] dptr_hi;
  logic [31:0] lba_lo;
  logic [31:0] lba_hi;
  logic [31:0] nlb_q;
  logic [31:0] command;
  logic        overflow;
  logic        cmd_pend;
  logic [7:0]  seq [16];
  logic        req;
  logic [3:0]  action;
  logic [QB-1:0] queue;
  logic [31:0] status_w;
  logic [31:0] level_w;

  assign req    = bus.cyc & bus.stb & ~bus.ack & ~bus.err;
  assign action = bus.dat_w[cmd_action_lsb +: 4];
  assign queue  = bus.dat_w[cmd_queue_lsb +: QB];

  // Held back while the target queue has no room
  assign cmd.valid = cmd_pend & ~sq_full[cmd.queue];

  always_comb begin
    status_w = '0;
    level_w  = '0;
    status_w[stat_sq_overflow] = overflow;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      status_w[stat_sq_full + q] = sq_full[q];
      level_w[8*q +: 8] = 8'(sq_level[q*LB +: LB]);
    end
  end

  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      control  <= '0;
      overflow <= 1'b0;
      cmd_pend <= 1'b0;
      bus.ack  <= 1'b0;
      bus.err  <= 1'b0;
      for (int i = 0; i < 16; i++) begin
        seq[i] <= '0;
      end
    end else begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
      if (cmd.valid && cmd.ready) begin
        cmd_pend <= 1'b0;
        bus.ack  <= 1'b1;
      end else if (req && !cmd_pend && bus.we) begin
        bus.ack <= 1'b1;
        case (reg_addr_e'(bus.adr))
          CONTROL: begin
            control <= bus.dat_w & ~(32'd1 << ctrl_clear_error);
            if (bus.dat_w[ctrl_clear_error]) begin
              overflow <= 1'b0;
            end
          end
          DPTR_LOW:  dptr_lo <= bus.dat_w;
          DPTR_HIGH: dptr_hi <= bus.dat_w;
          LBA_LOW:   lba_lo  <= bus.dat_w;
          LBA_HIGH:  lba_hi  <= bus.dat_w;
          NLB:       nlb_q   <= bus.dat_w;
          COMMAND: begin
            command <= bus.dat_w;
            bus.ack <= 1'b0;
            if (sq_full[queue] && control[ctrl_error_on_full]) begin
              bus.err  <= 1'b1;
              overflow <= 1'b1;
            end else begin
              cmd_pend    <= 1'b1;
              cmd.queue   <= queue;
              cmd.opcode  <= bus.dat_w[cmd_type_bit] ? NVME_WRITE : NVME_READ;
              cmd.cid     <= {seq[action], action, 4'(queue)};
              cmd.dptr    <= {dptr_hi, dptr_lo};
              cmd.lba     <= {lba_hi, lba_lo};
              cmd.nlb     <= nlb_q[15:0];
              seq[action] <= seq[action] + 8'd1;
            end
          end
          default: begin
            bus.ack <= 1'b0;
            bus.err <= 1'b1;
          end
        endcase
      end else if (req && !cmd_pend) begin
        bus.ack <= 1'b1;
        case (reg_addr_e'(bus.adr))
          CONTROL:   bus.dat_r <= control;
          STATUS:    bus.dat_r <= status_w;
          SQ_LEVEL:  bus.dat_r <= level_w;
          DPTR_LOW:  bus.dat_r <= dptr_lo;
          DPTR_HIGH: bus.dat_r <= dptr_hi;
          LBA_LOW:   bus.dat_r <= lba_lo;
          LBA_HIGH:  bus.dat_r <= lba_hi;
          NLB:       bus.dat_r <= nlb_q;
          COMMAND:   bus.dat_r <= command;
          default: begin
            bus.ack   <= 1'b0;
            bus.err   <= 1'b1;
            bus.dat_r <= '0;
          end
        endcase
      end
    end
  end

endmodule

//--- hw/nvme_host_if.sv
`timescale 1ns/10ps

// Wishbone classic register bus
interface reg_bus_if import nvme_host_pkg::*; ();
  logic                      cyc;
  logic                      stb;
  logic                      we;
  logic [host_addr_bits-1:0] adr;
  logic [31:0]               dat_w;
  logic [31:0]               dat_r;
  logic                      ack;
  logic                      err;

  modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack, err);
  modport slave  (input cyc, stb, we, adr, dat_w, output dat_r, ack, err);
endinterface

interface sq_cmd_if import nvme_host_pkg::*; #(parameter int NUM_QUEUES = 2) ();
  localparam int QB = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

  logic          valid;
  logic          ready;
  logic [QB-1:0] queue;
  nvme_opcode_e  opcode;
  logic [15:0]   cid;
  logic [63:0]   dptr;
  logic [63:0]   lba;
  logic [15:0]   nlb;

  modport source (output valid, queue, opcode, cid, dptr, lba, nlb, input ready);
  modport sink   (input valid, queue, opcode, cid, dptr, lba, nlb, output ready);
endinterface

// One source per CQ head, then one per SQ tail
interface doorbell_if #(parameter int NUM_QUEUES = 2) ();
  logic [2*NUM_QUEUES-1:0] req;
  logic [31:0]             addr [2*NUM_QUEUES];
  logic [31:0]             data [2*NUM_QUEUES];
  logic [2*NUM_QUEUES-1:0] done;

  modport requester (output req, addr, data, input done);
  modport writer    (input req, addr, data, output done);
endinterface

//--- hw/nvme_host_pkg.sv
package nvme_host_pkg;

  localparam int host_addr_bits = 8;

  // Host register byte offsets
  typedef enum logic [host_addr_bits-1:0] {
    CONTROL   = 8'h00,
    STATUS    = 8'h04,
    SQ_LEVEL  = 8'h08,
    DPTR_LOW  = 8'h10,
    DPTR_HIGH = 8'h14,
    LBA_LOW   = 8'h18,
    LBA_HIGH  = 8'h1C,
    NLB       = 8'h20,
    COMMAND   = 8'h24
  } reg_addr_e;

  // CONTROL and STATUS bits
  localparam int ctrl_error_on_full = 0;
  localparam int ctrl_clear_error   = 1;
  localparam int stat_sq_overflow   = 0;
  localparam int stat_sq_full       = 4;

  // COMMAND word fields
  localparam int cmd_type_bit   = 0;
  localparam int cmd_queue_lsb  = 4;
  localparam int cmd_action_lsb = 8;

  typedef enum logic [7:0] {
    NVME_WRITE = 8'h01,
    NVME_READ  = 8'h02
  } nvme_opcode_e;

  // Completion entry layout within a 128-bit receive beat
  localparam int cqe_sq_head_lsb = 64;
  localparam int cqe_cid_lsb     = 96;

  localparam logic [31:0] doorbell_base = 32'h0000_1000;

  // Queue q maps to NVMe queue q+1, SQ tail then CQ head
  function automatic logic [31:0] doorbell_addr(input int q, input logic is_cq);
    return doorbell_base + 32'(8 * (q + 1)) + (is_cq ? 32'd4 : 32'd0);
  endfunction

  // Completion entries occupy the bottom of the receive buffer
  function automatic int rx_cq_limit(input int num_queues, input int sq_depth);
    return num_queues * sq_depth;
  endfunction

endpackage

//--- hw/nvme_host_slave.sv
`timescale 1ns/10ps

module nvme_host_slave import nvme_host_pkg::*; #(
  parameter int NUM_QUEUES = 2,
  parameter int SQ_DEPTH   = 16,
  parameter int TX_ADDR_BITS = $clog2(NUM_QUEUES * SQ_DEPTH * 4),
  parameter int RX_ADDR_BITS = $clog2(NUM_QUEUES * SQ_DEPTH) + 1
) (
  input  logic                      axi_aclk,
  input  logic                      axi_aresetn,
  input  logic [host_addr_bits-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [31:0]               wdata,
  input  logic [3:0]                wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [host_addr_bits-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [31:0]               rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  output logic [3:0]                tx_write,
  output logic [TX_ADDR_BITS-1:0]   tx_waddr,
  output logic [127:0]              tx_wdata,
  input  logic                      rx_write_valid,
  input  logic [RX_ADDR_BITS-1:0]   rx_waddr,
  input  logic [127:0]              rx_wdata,
  output logic                      pcie_write,
  output logic [31:0]               pcie_waddr,
  output logic [31:0]               pcie_wdata,
  input  logic                      pcie_wdone
);

  localparam int QB = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
  localparam int PB = $clog2(SQ_DEPTH);

  logic [NUM_QUEUES*PB-1:0] sq_tail;
  logic [NUM_QUEUES*PB-1:0] sq_level;
  logic [NUM_QUEUES-1:0]    sq_full;
  logic                     entry_done;
  logic [QB-1:0]            entry_queue;

  reg_bus_if                          reg_bus ();
  sq_cmd_if   #(.NUM_QUEUES(NUM_QUEUES)) sq_cmd ();
  doorbell_if #(.NUM_QUEUES(NUM_QUEUES)) db ();

  host_axil_port host_axil_port_i (.*, .bus(reg_bus.master));

  host_regs #(.NUM_QUEUES(NUM_QUEUES), .SQ_DEPTH(SQ_DEPTH)) host_regs_i (
    .axi_aclk, .axi_aresetn, .bus(reg_bus.slave), .cmd(sq_cmd.source), .sq_full, .sq_level
  );

  queue_tracker #(
    .NUM_QUEUES(NUM_QUEUES), .SQ_DEPTH(SQ_DEPTH), .RX_ADDR_BITS(RX_ADDR_BITS)
  ) queue_tracker_i (
    .axi_aclk, .axi_aresetn, .rx_write_valid, .rx_waddr, .rx_wdata, .entry_done,
    .entry_queue, .sq_tail, .sq_full, .sq_level, .db(db.requester)
  );

  sq_cmd_builder #(
    .NUM_QUEUES(NUM_QUEUES), .SQ_DEPTH(SQ_DEPTH), .TX_ADDR_BITS(TX_ADDR_BITS)
  ) sq_cmd_builder_i (
    .axi_aclk, .axi_aresetn, .cmd(sq_cmd.sink), .sq_tail, .tx_write, .tx_waddr,
    .tx_wdata, .entry_done, .entry_queue
  );

  doorbell_writer #(.NUM_QUEUES(NUM_QUEUES)) doorbell_writer_i (
    .axi_aclk, .axi_aresetn, .db(db.writer), .pcie_write, .pcie_waddr, .pcie_wdata,
    .pcie_wdone
  );

endmodule

//--- hw/queue_tracker.sv
`timescale 1ns/10ps

module queue_tracker import nvme_host_pkg::*; #(
  parameter int NUM_QUEUES   = 2,
  parameter int SQ_DEPTH     = 16,
  parameter int RX_ADDR_BITS = 6
) (
  input  logic                                   axi_aclk,
  input  logic                                   axi_aresetn,
  input  logic                                   rx_write_valid,
  input  logic [RX_ADDR_BITS-1:0]                rx_waddr,
  input  logic [127:0]                           rx_wdata,
  input  logic                                   entry_done,
  input  logic [((NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1)-1:0] entry_queue,
  output logic [NUM_QUEUES*$clog2(SQ_DEPTH)-1:0] sq_tail,
  output logic [NUM_QUEUES-1:0]                  sq_full,
  output logic [NUM_QUEUES*$clog2(SQ_DEPTH)-1:0] sq_level,
  doorbell_if.requester                          db
);

  localparam int QB = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
  localparam int PB = $clog2(SQ_DEPTH);

  logic [PB-1:0] tail    [NUM_QUEUES];
  logic [PB-1:0] head    [NUM_QUEUES];
  logic [PB-1:0] cq_head [NUM_QUEUES];
  logic          cqe_hit;
  logic [QB-1:0] cqe_queue;

  assign cqe_hit   = rx_write_valid &&
                     (int'(rx_waddr) < rx_cq_limit(NUM_QUEUES, SQ_DEPTH));
  assign cqe_queue = rx_wdata[cqe_cid_lsb +: QB];

  always_comb begin
    for (int q = 0; q < NUM_QUEUES; q++) begin
      sq_tail[q*PB +: PB]  = tail[q];
      sq_level[q*PB +: PB] = (tail[q] >= head[q]) ? tail[q] - head[q]
                                                  : PB'(SQ_DEPTH + tail[q] - head[q]);
      sq_full[q] = (sq_level[q*PB +: PB] == PB'(SQ_DEPTH - 1));
      db.addr[q]              = doorbell_addr(q, 1'b1);
      db.data[q]              = 32'(cq_head[q]);
      db.addr[NUM_QUEUES + q] = doorbell_addr(q, 1'b0);
      db.data[NUM_QUEUES + q] = 32'(tail[q]);
    end
  end

  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      db.req <= '0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        tail[q]    <= '0;
        head[q]    <= '0;
        cq_head[q] <= '0;
      end
    end else begin
      // A fresh request overrides the clear of the same source
      db.req <= db.req & ~db.done;
      if (entry_done) begin
        tail[entry_queue] <= (tail[entry_queue] == PB'(SQ_DEPTH - 1)) ? '0
                                                                      : tail[entry_queue] + 1'b1;
        db.req[NUM_QUEUES + int'(entry_queue)] <= 1'b1;
      end
      if (cqe_hit) begin
        head[cqe_queue]    <= rx_wdata[cqe_sq_head_lsb +: PB];
        cq_head[cqe_queue] <= (cq_head[cqe_queue] == PB'(SQ_DEPTH - 1)) ? '0
                                                                        : cq_head[cqe_queue] + 1'b1;
        db.req[cqe_queue]  <= 1'b1;
      end
    end
  end

endmodule

//--- hw/sq_cmd_builder.sv
`timescale 1ns/10ps

module sq_cmd_builder import nvme_host_pkg::*; #(
  parameter int NUM_QUEUES   = 2,
  parameter int SQ_DEPTH     = 16,
  parameter int TX_ADDR_BITS = 7
) (
  input  logic                                   axi_aclk,
  input  logic                                   axi_aresetn,
  sq_cmd_if.sink                                 cmd,
  input  logic [NUM_QUEUES*$clog2(SQ_DEPTH)-1:0] sq_tail,
  output logic [3:0]                             tx_write,
  output logic [TX_ADDR_BITS-1:0]                tx_waddr,
  output logic [127:0]                           tx_wdata,
  output logic                                   entry_done,
  output logic [((NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1)-1:0] entry_queue
);

  localparam int PB = $clog2(SQ_DEPTH);

  typedef enum logic {ST_IDLE, ST_BUILD} state_e;

  state_e       state;
  logic [1:0]   beat;
  nvme_opcode_e opcode;
  logic [15:0]  cid;
  logic [63:0]  dptr;
  logic [63:0]  lba;
  logic [15:0]  nlb;

  assign cmd.ready = (state == ST_IDLE);

  always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      state      <= ST_IDLE;
      beat       <= '0;
      tx_write   <= 4'h0;
      entry_done <= 1'b0;
    end else begin
      tx_write   <= 4'h0;
      entry_done <= 1'b0;
      if (state == ST_IDLE && cmd.valid) begin
        state       <= ST_BUILD;
        beat        <= '0;
        entry_queue <= cmd.queue;
        opcode      <= cmd.opcode;
        cid         <= cmd.cid;
        dptr        <= cmd.dptr;
        lba         <= cmd.lba;
        nlb         <= cmd.nlb;
      end else if (state == ST_BUILD) begin
        tx_write <= 4'hf;
        tx_waddr <= TX_ADDR_BITS'((int'(entry_queue) * SQ_DEPTH +
                                  int'(sq_tail[entry_queue*PB +: PB])) * 4 + int'(beat));
        case (beat)
          // PRP format, no fuse
          2'd0:    tx_wdata <= {96'd0, cid, 2'b00, 4'b0000, 2'b00, opcode};
          2'd1:    tx_wdata <= {dptr, 64'd0};
          2'd2:    tx_wdata <= {lba, 64'd0};
          default: tx_wdata <= {112'd0, nlb};
        endcase
        beat <= beat + 2'd1;
        if (beat == 2'd3) begin
          state      <= ST_IDLE;
          entry_done <= 1'b1;
        end
      end
    end
  end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real PERIOD_NS    = 40.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic axi_aclk,
  output logic axi_aresetn
);

  initial begin
    axi_aclk = 1'b0;
    forever #(PERIOD_NS / 2.0) axi_aclk = ~axi_aclk;
  end

  // Release away from the rising edge
  initial begin
    axi_aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge axi_aclk);
    @(negedge axi_aclk);
    axi_aresetn = 1'b1;
  end

endmodule

//--- include/tb_nvme_cases.svh
`ifndef TB_NVME_CASES_SVH
`define TB_NVME_CASES_SVH

// Columns are op, register offset or rx address, data, repeat count, response, expected value
// Commands expect the last SQ tail doorbell value, completions the CQ head doorbell value
localparam int num_cases = 29;
localparam case_t cases [num_cases] = '{
  '{OP_WR,  8'h10, 32'h8000_1000, 8'd1,  2'b00, 32'h0000_0000},
  '{OP_WR,  8'h14, 32'h0000_0012, 8'd1,  2'b00, 32'h0000_0000},
  '{OP_WR,  8'h18, 32'h0000_0400, 8'd1,  2'b00, 32'h0000_0000},
  '{OP_WR,  8'h1C, 32'h0000_0003, 8'd1,  2'b00, 32'h0000_0000},
  '{OP_WR,  8'h20, 32'h0000_0007, 8'd1,  2'b00, 32'h0000_0000},
  '{OP_RD,  8'h10, 32'h0000_0000, 8'd1,  2'b00, 32'h8000_1000},
  '{OP_RD,  8'h14, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0012},
  '{OP_RD,  8'h18, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0400},
  '{OP_RD,  8'h1C, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0003},
  '{OP_RD,  8'h20, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0007},
  // Error on full set together with clear error
  // Clear error reads back as zero
  '{OP_WR,  8'h00, 32'h0000_0003, 8'd1,  2'b00, 32'h0000_0000},
  '{OP_RD,  8'h00, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0001},
  '{OP_WR,  8'h30, 32'h0000_BEEF, 8'd1,  2'b10, 32'h0000_0000},
  '{OP_RD,  8'h2C, 32'h0000_0000, 8'd1,  2'b10, 32'h0000_0000},
  '{OP_CMD, 8'h24, 32'h0000_0300, 8'd1,  2'b00, 32'h0000_0001},
  '{OP_CMD, 8'h24, 32'h0000_0301, 8'd1,  2'b00, 32'h0000_0002},
  '{OP_CMD, 8'h24, 32'h0000_0511, 8'd1,  2'b00, 32'h0000_0001},
  '{OP_RD,  8'h08, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0102},
  // Completion data has the queue in bits 7:4 and the SQ head in bits 19:16
  '{OP_CPL, 8'h00, 32'h0001_0000, 8'd1,  2'b00, 32'h0000_0001},
  '{OP_RD,  8'h08, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0101},
  '{OP_CPL, 8'h01, 32'h0001_0010, 8'd1,  2'b00, 32'h0000_0001},
  '{OP_CMD, 8'h24, 32'h0000_0511, 8'd15, 2'b00, 32'h0000_0000},
  '{OP_RD,  8'h04, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0020},
  '{OP_CMD, 8'h24, 32'h0000_0511, 8'd1,  2'b10, 32'h0000_0000},
  '{OP_RD,  8'h04, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0021},
  '{OP_WR,  8'h00, 32'h0000_0003, 8'd1,  2'b00, 32'h0000_0000},
  '{OP_RD,  8'h04, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0020},
  '{OP_CPL, 8'h02, 32'h0005_0010, 8'd1,  2'b00, 32'h0000_0002},
  '{OP_RD,  8'h08, 32'h0000_0000, 8'd1,  2'b00, 32'h0000_0B01}
};

`endif

//--- testbench/tb_nvme_host_slave.sv
`timescale 1ns/10ps

module tb_nvme_host_slave import nvme_host_pkg::*; ();

  localparam int num_queues   = 2;
  localparam int sq_depth     = 16;
  localparam int tx_addr_bits = $clog2(num_queues * sq_depth * 4);
  localparam int rx_addr_bits = $clog2(num_queues * sq_depth) + 1;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_CMD, OP_CPL} op_e;

  typedef struct packed {
    op_e         op;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [7:0]  count;
    logic [1:0]  resp;
    logic [31:0] value;
  } case_t;

  `include "tb_nvme_cases.svh"

  logic                    axi_aclk;
  logic                    axi_aresetn;
  logic [7:0]              awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [31:0]             wdata;
  logic [3:0]              wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [7:0]              araddr;
  logic                    arvalid;
  logic                    arready;
  logic [31:0]             rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;
  logic [3:0]              tx_write;
  logic [tx_addr_bits-1:0] tx_waddr;
  logic [127:0]            tx_wdata;
  logic                    rx_write_valid;
  logic [rx_addr_bits-1:0] rx_waddr;
  logic [127:0]            rx_wdata;
  logic                    pcie_write;
  logic [31:0]             pcie_waddr;
  logic [31:0]             pcie_wdata;
  logic                    pcie_wdone;

  // Reference state of the host-side queues
  logic [63:0] ref_dptr;
  logic [63:0] ref_lba;
  logic [31:0] ref_nlb;
  int          ref_tail [num_queues];
  int          ref_cq_head [num_queues];
  logic [7:0]  ref_seq [16];
  logic [31:0] last_db_data;

  logic [tx_addr_bits-1:0] tx_addr_log [$];
  logic [127:0]            tx_data_log [$];
  logic [31:0]             db_addr_log [$];
  logic [31:0]             db_data_log [$];

  int cycle_count = 0;
  int cycle_limit = 0;

  tb_clock_gen #(.PERIOD_NS(40.0), .RESET_CYCLES(8)) clock_gen_i (.axi_aclk, .axi_aresetn);

  nvme_host_slave #(
    .NUM_QUEUES(num_queues), .SQ_DEPTH(sq_depth),
    .TX_ADDR_BITS(tx_addr_bits), .RX_ADDR_BITS(rx_addr_bits)
  ) nvme_host_slave_i (.*);

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    logic aw_hs;
    logic w_hs;
    @(negedge axi_aclk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hf;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (awvalid || wvalid) begin
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(negedge axi_aclk);
      if (aw_hs) awvalid = 1'b0;
      if (w_hs) wvalid = 1'b0;
    end
    while (!bvalid) @(negedge axi_aclk);
    resp = bresp;
    @(negedge axi_aclk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    logic ar_hs;
    @(negedge axi_aclk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (arvalid) begin
      ar_hs = arready;
      @(negedge axi_aclk);
      if (ar_hs) arvalid = 1'b0;
    end
    while (!rvalid) @(negedge axi_aclk);
    data = rdata;
    resp = rresp;
    @(negedge axi_aclk);
    rready = 1'b0;
  endtask

  // One COMMAND write, then its four entry beats and its SQ tail doorbell
  task automatic run_command(input logic [7:0] addr, input logic [31:0] word,
                             input logic [1:0] exp_resp);
    logic [1:0]   resp;
    int           q;
    logic [3:0]   action;
    logic [15:0]  cid;
    logic [7:0]   opcode;
    logic [127:0] beat [4];
    q      = int'(word[cmd_queue_lsb +: 4]);
    action = word[cmd_action_lsb +: 4];
    axi_write(addr, word, resp);
    check_value("bresp", resp, exp_resp);
    if (exp_resp == 2'b00) begin
      // NVMe write is 0x01, read is 0x02
      opcode  = word[cmd_type_bit] ? 8'h01 : 8'h02;
      cid     = {ref_seq[action], action, 4'(q)};
      beat[0] = {96'd0, cid, 8'h00, opcode};
      beat[1] = {ref_dptr, 64'd0};
      beat[2] = {ref_lba, 64'd0};
      beat[3] = {112'd0, ref_nlb[15:0]};
      while (tx_addr_log.size() < 4) @(negedge axi_aclk);
      for (int b = 0; b < 4; b++) begin
        check_value("tx_waddr", tx_addr_log.pop_front(), (q * sq_depth + ref_tail[q]) * 4 + b);
        check_value("tx_wdata", tx_data_log.pop_front(), beat[b]);
      end
      ref_tail[q]     = (ref_tail[q] + 1) % sq_depth;
      ref_seq[action] = ref_seq[action] + 8'd1;
      while (db_addr_log.size() == 0) @(negedge axi_aclk);
      last_db_data = db_data_log.pop_front();
      check_value("pcie_waddr", db_addr_log.pop_front(), 32'h1000 + 8 * (q + 1));
      check_value("pcie_wdata", last_db_data, ref_tail[q]);
    end
  endtask

  // Completion data holds the queue in bits 7:4 and the SQ head in bits 19:16
  task automatic run_completion(input logic [7:0] addr, input logic [31:0] data,
                                input logic [31:0] exp_value);
    int q;
    q = int'(data[7:4]);
    @(negedge axi_aclk);
    rx_write_valid         = 1'b1;
    rx_waddr               = rx_addr_bits'(addr);
    rx_wdata               = '0;
    rx_wdata[64 +: 16]     = {12'd0, data[19:16]};
    rx_wdata[96 +: 4]      = 4'(q);
    @(negedge axi_aclk);
    rx_write_valid = 1'b0;
    ref_cq_head[q] = (ref_cq_head[q] + 1) % sq_depth;
    while (db_addr_log.size() == 0) @(negedge axi_aclk);
    last_db_data = db_data_log.pop_front();
    check_value("pcie_waddr", db_addr_log.pop_front(), 32'h1000 + 8 * (q + 1) + 4);
    check_value("pcie_wdata", last_db_data, ref_cq_head[q]);
    check_value("pcie_wdata", last_db_data, exp_value);
  endtask

  task automatic apply_case(input case_t c);
    logic [1:0]  resp;
    logic [31:0] rd;
    check_value("tx beat backlog", tx_addr_log.size(), 0);
    check_value("doorbell backlog", db_addr_log.size(), 0);
    case (c.op)
      OP_WR: begin
        axi_write(c.addr, c.data, resp);
        check_value("bresp", resp, c.resp);
        case (c.addr)
          DPTR_LOW:  ref_dptr[31:0]  = c.data;
          DPTR_HIGH: ref_dptr[63:32] = c.data;
          LBA_LOW:   ref_lba[31:0]   = c.data;
          LBA_HIGH:  ref_lba[63:32]  = c.data;
          NLB:       ref_nlb         = c.data;
          default: ;
        endcase
      end
      OP_RD: begin
        axi_read(c.addr, rd, resp);
        check_value("rresp", resp, c.resp);
        if (c.resp == 2'b00) begin
          check_value("rdata", rd, c.value);
        end
      end
      OP_CMD: begin
        for (int n = 0; n < int'(c.count); n++) begin
          run_command(c.addr, c.data, c.resp);
        end
        if (c.resp == 2'b00) begin
          check_value("sq tail doorbell", last_db_data, c.value);
        end
      end
      default: run_completion(c.addr, c.data, c.value);
    endcase
  endtask

  // PCIe completer with a random write latency
  initial begin
    int delay;
    pcie_wdone = 1'b0;
    void'($urandom(79));
    forever begin
      @(negedge axi_aclk);
      if (pcie_write) begin
        db_addr_log.push_back(pcie_waddr);
        db_data_log.push_back(pcie_wdata);
        delay = 1 + int'($urandom % 4);
        repeat (delay - 1) @(negedge axi_aclk);
        pcie_wdone = 1'b1;
        @(negedge axi_aclk);
        pcie_wdone = 1'b0;
      end
    end
  end

  // Tx buffer model
  always @(negedge axi_aclk) begin
    if (axi_aresetn && tx_write != 4'h0) begin
      check_value("tx_write", tx_write, 4'hf);
      tx_addr_log.push_back(tx_waddr);
      tx_data_log.push_back(tx_wdata);
    end
  end

  always @(posedge axi_aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles waiting for the DUT", cycle_count));
    end
  end

  initial begin
    int total;
    awaddr         = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wstrb          = 4'h0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    rx_write_valid = 1'b0;
    rx_waddr       = '0;
    rx_wdata       = '0;
    ref_dptr       = '0;
    ref_lba        = '0;
    ref_nlb        = '0;
    last_db_data   = '0;
    for (int q = 0; q < num_queues; q++) begin
      ref_tail[q]    = 0;
      ref_cq_head[q] = 0;
    end
    for (int a = 0; a < 16; a++) begin
      ref_seq[a] = 8'd0;
    end
    total = 0;
    for (int i = 0; i < num_cases; i++) begin
      total += int'(cases[i].count);
    end
    cycle_limit = total * 200;

    // Handshake and write strobes stay low while in reset
    repeat (2) @(negedge axi_aclk);
    check_value("outputs in reset",
                {awready, wready, bvalid, arready, rvalid, tx_write, pcie_write}, '0);
    wait (axi_aresetn === 1'b1);

    for (int i = 0; i < num_cases; i++) begin
      apply_case(cases[i]);
    end
    check_value("tx beat backlog", tx_addr_log.size(), 0);
    check_value("doorbell backlog", db_addr_log.size(), 0);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
